/* ifetch_macros.svh */
`ifndef IFETCH_MACROS_SVH
`define IFETCH_MACROS_SVH

// byte address width of the fetch path
`define IFETCH_ADDR_W 32

// direct-mapped lines, one 32-bit word each, power of two
`define ICACHE_LINES 16

// first fetch address after reset
`define IFETCH_RESET_PC 32'h0000_0000

// index sits right above the two byte-offset bits
`define ICACHE_IDX_LSB 2
`define ICACHE_IDX_W $clog2(`ICACHE_LINES)

// tag is everything above the index
`define ICACHE_TAG_LSB (`ICACHE_IDX_LSB + `ICACHE_IDX_W)
`define ICACHE_TAG_W (`IFETCH_ADDR_W - `ICACHE_TAG_LSB)

// opcode bit that selects the immediate view
`define IFETCH_IMM_SEL_BIT 5

`endif

/* ifetch_pkg.sv */
`include "ifetch_macros.svh"

package ifetch_pkg;

    // jump is i-form, target = pc + 4 * sext(imm)
    localparam logic [5:0] opcode_jmp = 6'h3f;

    typedef struct packed {
        logic [`IFETCH_ADDR_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [10:0] funct;
    } instr_r_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [15:0] imm;
    } instr_i_t;

    // same word, two formats; opcode bit 5 picks the i view
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        logic [`IFETCH_ADDR_W-1:0] pc;
        instr_u                    instr;
    } fetch_rsp_t;

    typedef struct packed {
        logic [`IFETCH_ADDR_W-1:0] pc;
        logic [5:0]                opcode;
        logic [4:0]                rd;
        logic [4:0]                rs1;
        logic                      is_imm;
        logic [31:0]               operand;
        logic [10:0]               funct;
    } decoded_t;

    typedef struct packed {
        logic [`IFETCH_ADDR_W-1:0] addr;
        logic [2:0]                prot;
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axil_r_t;

endpackage

/* fetch_unit.sv */
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module fetch_unit (
    input  logic                      clk,
    input  logic                      rst,
    output logic                      req_valid,
    output ifetch_pkg::fetch_req_t    req,
    input  logic                      req_ready,
    input  logic                      redirect_valid,
    input  logic [`IFETCH_ADDR_W-1:0] redirect_pc
);

    logic [`IFETCH_ADDR_W-1:0] pc_q;
    logic [`IFETCH_ADDR_W-1:0] pc_next;
    logic                      valid_q;
    logic                      req_fire;

    assign req_fire = req_valid && req_ready;

    // redirect wins over the increment, even for an unaccepted request
    always_comb
    begin
        if (redirect_valid)
        begin
            pc_next = redirect_pc;
        end
        else if (req_fire)
        begin
            pc_next = pc_q + `IFETCH_ADDR_W'(4);
        end
        else
        begin
            pc_next = pc_q;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc_q    <= `IFETCH_RESET_PC;
            valid_q <= 1'b0;
        end
        else
        begin
            pc_q    <= pc_next;
            // requests run continuously once out of reset
            valid_q <= 1'b1;
        end
    end

    assign req_valid = valid_q;
    assign req.addr  = {pc_q[`IFETCH_ADDR_W-1:2], 2'b00};

endmodule

/* icache.sv */
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module icache (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  ifetch_pkg::fetch_req_t req,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output ifetch_pkg::fetch_rsp_t rsp,
    input  logic                   rsp_ready,
    output logic                   ar_valid,
    output ifetch_pkg::axil_ar_t   ar,
    input  logic                   ar_ready,
    input  logic                   r_valid,
    input  ifetch_pkg::axil_r_t    r,
    output logic                   r_ready
);

    localparam int lines   = `ICACHE_LINES;
    localparam int idx_w   = `ICACHE_IDX_W;
    localparam int idx_lsb = `ICACHE_IDX_LSB;
    localparam int tag_w   = `ICACHE_TAG_W;
    localparam int tag_lsb = `ICACHE_TAG_LSB;

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait
    } miss_state_t;

    miss_state_t state_q;

    // line store
    logic [lines-1:0] line_valid_q;
    logic [tag_w-1:0] tag_mem  [lines];
    logic [31:0]      data_mem [lines];

    logic [idx_w-1:0]          req_idx;
    logic [tag_w-1:0]          req_tag;
    logic                      hit;
    logic                      req_fire;
    logic                      rsp_free;
    logic                      hit_load;
    logic                      fill_load;
    logic [`IFETCH_ADDR_W-1:0] miss_addr_q;
    logic [idx_w-1:0]          miss_idx;
    logic [tag_w-1:0]          miss_tag;
    logic                      rsp_valid_q;
    ifetch_pkg::fetch_rsp_t    rsp_q;

    assign req_idx  = req.addr[idx_lsb +: idx_w];
    assign req_tag  = req.addr[tag_lsb +: tag_w];
    assign miss_idx = miss_addr_q[idx_lsb +: idx_w];
    assign miss_tag = miss_addr_q[tag_lsb +: tag_w];

    assign hit = line_valid_q[req_idx] && (tag_mem[req_idx] == req_tag);

    // response register can take a word when empty or draining this cycle
    assign rsp_free  = !rsp_valid_q || rsp_ready;
    assign req_ready = (state_q == st_idle) && rsp_free;
    assign req_fire  = req_valid && req_ready;
    assign hit_load  = req_fire && hit;

    // hold the R beat until the response register has room
    assign r_ready   = (state_q == st_wait) && rsp_free;
    assign fill_load = r_valid && r_ready;

    assign ar_valid  = (state_q == st_req);
    assign ar.addr   = miss_addr_q;
    // unprivileged, secure, instruction access
    assign ar.prot   = 3'b100;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= st_idle;
        end
        else
        begin
            case (state_q)
                st_idle:
                begin
                    if (req_fire && !hit)
                    begin
                        state_q <= st_req;
                    end
                end
                st_req:
                begin
                    if (ar_ready)
                    begin
                        state_q <= st_wait;
                    end
                end
                st_wait:
                begin
                    if (fill_load)
                    begin
                        state_q <= st_idle;
                    end
                end
                default:
                begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_fire && !hit)
        begin
            miss_addr_q <= req.addr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            line_valid_q <= '0;
        end
        else if (fill_load)
        begin
            // resp is ignored, an error beat still fills the line
            line_valid_q[miss_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_load)
        begin
            tag_mem[miss_idx]  <= miss_tag;
            data_mem[miss_idx] <= r.data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rsp_valid_q <= 1'b0;
        end
        else if (hit_load || fill_load)
        begin
            rsp_valid_q <= 1'b1;
        end
        else if (rsp_ready)
        begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (hit_load)
        begin
            rsp_q.pc    <= req.addr;
            rsp_q.instr <= data_mem[req_idx];
        end
        else if (fill_load)
        begin
            rsp_q.pc    <= miss_addr_q;
            rsp_q.instr <= r.data;
        end
    end

    assign rsp_valid = rsp_valid_q;
    assign rsp       = rsp_q;

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module decode_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rsp_valid,
    input  ifetch_pkg::fetch_rsp_t    rsp,
    output logic                      rsp_ready,
    output logic                      dec_valid,
    output ifetch_pkg::decoded_t      dec,
    input  logic                      dec_ready,
    output logic                      redirect_valid,
    output logic [`IFETCH_ADDR_W-1:0] redirect_pc
);

    logic [`IFETCH_ADDR_W-1:0] exp_pc_q;
    logic                      on_path;
    logic                      is_imm;
    logic                      is_jmp;
    logic                      dec_fire;
    logic [31:0]               imm_ext;
    logic [`IFETCH_ADDR_W-1:0] jmp_target;

    // words fetched past a taken jump carry the wrong pc
    assign on_path   = (rsp.pc == exp_pc_q);
    assign dec_valid = rsp_valid && on_path;
    assign rsp_ready = dec_ready || !on_path;
    assign dec_fire  = dec_valid && dec_ready;

    assign is_imm  = rsp.instr.r.opcode[`IFETCH_IMM_SEL_BIT];
    assign is_jmp  = (rsp.instr.i.opcode == ifetch_pkg::opcode_jmp);
    assign imm_ext = {{16{rsp.instr.i.imm[15]}}, rsp.instr.i.imm};

    // imm is a word offset scaled by 4
    assign jmp_target = rsp.pc
        + {{(`IFETCH_ADDR_W - 18){rsp.instr.i.imm[15]}}, rsp.instr.i.imm, 2'b00};

    always_comb
    begin
        dec.pc     = rsp.pc;
        // opcode, rd and rs1 sit in the same bits of both views
        dec.opcode = rsp.instr.r.opcode;
        dec.rd     = rsp.instr.r.rd;
        dec.rs1    = rsp.instr.r.rs1;
        dec.is_imm = is_imm;
        if (is_imm)
        begin
            dec.operand = imm_ext;
            dec.funct   = '0;
        end
        else
        begin
            dec.operand = {27'b0, rsp.instr.r.rs2};
            dec.funct   = rsp.instr.r.funct;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            exp_pc_q <= `IFETCH_RESET_PC;
        end
        else if (dec_fire)
        begin
            exp_pc_q <= is_jmp ? jmp_target : rsp.pc + `IFETCH_ADDR_W'(4);
        end
    end

    // pulse in the cycle the jump leaves on dec
    assign redirect_valid = dec_fire && is_jmp;
    assign redirect_pc    = jmp_target;

endmodule

/* ifetch_top.sv */
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module ifetch_top (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 ar_valid,
    output ifetch_pkg::axil_ar_t ar,
    input  logic                 ar_ready,
    input  logic                 r_valid,
    input  ifetch_pkg::axil_r_t  r,
    output logic                 r_ready,
    output logic                 dec_valid,
    output ifetch_pkg::decoded_t dec,
    input  logic                 dec_ready
);

    logic                      req_valid;
    ifetch_pkg::fetch_req_t    req;
    logic                      req_ready;
    logic                      rsp_valid;
    ifetch_pkg::fetch_rsp_t    rsp;
    logic                      rsp_ready;
    logic                      redirect_valid;
    logic [`IFETCH_ADDR_W-1:0] redirect_pc;

    fetch_unit i_fetch_unit (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req            (req),
        .req_ready      (req_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    icache i_icache (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .ar_valid  (ar_valid),
        .ar        (ar),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r         (r),
        .r_ready   (r_ready)
    );

    decode_stage i_decode_stage (
        .clk            (clk),
        .rst            (rst),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .rsp_ready      (rsp_ready),
        .dec_valid      (dec_valid),
        .dec            (dec),
        .dec_ready      (dec_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

/* ifetch_assert.sv */
`timescale 1ns/1ps

module ifetch_assert (
    input logic                 clk,
    input logic                 rst,
    input logic                 ar_valid,
    input ifetch_pkg::axil_ar_t ar,
    input logic                 ar_ready,
    input logic                 rsp_valid,
    input logic                 dec_valid,
    input ifetch_pkg::decoded_t dec,
    input logic                 dec_ready
);

    // stalled AR keeps its address
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else $error("AR dropped or changed while stalled");

    dec_hold: assert property (@(posedge clk) disable iff (rst)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec))
        else $error("decoded output dropped or changed while stalled");

    // first cycle out of reset
    reset_quiet: assert property (@(posedge clk)
        $fell(rst) |-> !ar_valid && !rsp_valid && !dec_valid)
        else $error("valid raised in the first cycle after reset");

endmodule

bind ifetch_top ifetch_assert i_ifetch_assert (
    .clk       (clk),
    .rst       (rst),
    .ar_valid  (ar_valid),
    .ar        (ar),
    .ar_ready  (ar_ready),
    .rsp_valid (rsp_valid),
    .dec_valid (dec_valid),
    .dec       (dec),
    .dec_ready (dec_ready)
);

/* tb_ifetch.sv */
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module tb_ifetch;

    localparam int wait_limit = 2000;
    localparam int mem_words  = 64;

    logic                 clk;
    logic                 rst;
    logic                 ar_valid;
    ifetch_pkg::axil_ar_t ar;
    logic                 ar_ready;
    logic                 r_valid;
    ifetch_pkg::axil_r_t  r;
    logic                 r_ready;
    logic                 dec_valid;
    ifetch_pkg::decoded_t dec;
    logic                 dec_ready;

    // memory model state
    logic [31:0] mem [mem_words];
    int          ar_count [mem_words];
    logic [31:0] rd_addr;
    logic        rd_pending;
    int          ar_delay;
    int          r_delay;
    int          stall_left;
    logic        bp_en;
    logic [31:0] lfsr_state;

    ifetch_top i_ifetch_top (
        .clk       (clk),
        .rst       (rst),
        .ar_valid  (ar_valid),
        .ar        (ar),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r         (r),
        .r_ready   (r_ready),
        .dec_valid (dec_valid),
        .dec       (dec),
        .dec_ready (dec_ready)
    );

    always #2 clk = ~clk;

    // galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic next_random_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b)
        begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic int random_bits(input int n);
        int val;
        val = 0;
        for (int k = 0; k < n; k++)
        begin
            val = (val << 1) | int'(next_random_bit());
        end
        return val;
    endfunction

    function automatic logic [31:0] r_word(input logic [5:0] op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [10:0] funct);
        return {op, rd, rs1, rs2, funct};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [15:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    // expected decode of the word at pc from the field layout
    function automatic ifetch_pkg::decoded_t predict(input logic [31:0] pc);
        ifetch_pkg::decoded_t d;
        logic [31:0]          w;
        w = mem[pc[7:2]];
        d.pc = pc;
        d.opcode = w[31:26];
        d.rd = w[25:21];
        d.rs1 = w[20:16];
        d.is_imm = w[31];
        if (d.is_imm)
        begin
            d.operand = 32'(int'($signed(w[15:0])));
            d.funct = '0;
        end
        else
        begin
            d.operand = {27'd0, w[15:11]};
            d.funct = w[10:0];
        end
        return d;
    endfunction

    function automatic logic [31:0] next_pc(input logic [31:0] pc);
        logic [31:0] w;
        w = mem[pc[7:2]];
        if (w[31:26] == 6'h3f)
        begin
            return pc + 32'(4 * int'($signed(w[15:0])));
        end
        return pc + 32'd4;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        if (got !== exp)
        begin
            fail_run($sformatf("[ERROR] %0t: %s: got %h, expected %h", $time, what, got, exp));
        end
    endtask

    // AXI4-Lite slave and dec_ready driven on the falling edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            ar_ready = 1'b0;
            r_valid = 1'b0;
            ar_delay = -1;
            r_delay = -1;
        end
        else
        begin
            if (!ar_valid)
            begin
                ar_ready = 1'b0;
                ar_delay = -1;
            end
            else if (!ar_ready)
            begin
                if (ar_delay < 0)
                begin
                    ar_delay = random_bits(2);
                end
                if (ar_delay == 0)
                begin
                    ar_ready = 1'b1;
                end
                else
                begin
                    ar_delay--;
                end
            end
            if (!rd_pending)
            begin
                r_valid = 1'b0;
                r_delay = -1;
            end
            else if (!r_valid)
            begin
                if (r_delay < 0)
                begin
                    r_delay = random_bits(2);
                end
                if (r_delay == 0)
                begin
                    r_valid = 1'b1;
                    r.data = mem[rd_addr[7:2]];
                    r.resp = 2'b00;
                end
                else
                begin
                    r_delay--;
                end
            end
        end
        if (bp_en && stall_left > 0)
        begin
            dec_ready = 1'b0;
            stall_left--;
        end
        else
        begin
            dec_ready = 1'b1;
            stall_left = bp_en ? random_bits(2) : 0;
        end
    end

    // handshake bookkeeping with one read outstanding
    always @(posedge clk)
    begin
        if (rst)
        begin
            rd_pending <= 1'b0;
        end
        else if (ar_valid && ar_ready)
        begin
            // AxPROT bit 2 marks an instruction access
            check_equal(ar.prot[2], 1'b1, "AR prot instruction bit");
            ar_count[ar.addr[7:2]] <= ar_count[ar.addr[7:2]] + 1;
            rd_addr <= ar.addr;
            rd_pending <= 1'b1;
        end
        else if (r_valid && r_ready)
        begin
            rd_pending <= 1'b0;
        end
    end

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (10) @(negedge clk);
        for (int k = 0; k < mem_words; k++)
        begin
            ar_count[k] = 0;
        end
        rst = 1'b0;
    endtask

    // fill words are r-form and carry their own address
    task automatic load_fill();
        for (int k = 0; k < mem_words; k++)
        begin
            mem[k] = {6'h01, 26'(k * 4)};
        end
    endtask

    task automatic load_straight();
        load_fill();
        mem[0] = r_word(6'h01, 5'd1, 5'd2, 5'd31, 11'h7ff);
        mem[1] = i_word(6'h20, 5'd3, 5'd4, 16'hfff0);
        mem[2] = r_word(6'h1f, 5'd31, 5'd0, 5'd5, 11'h001);
        mem[3] = i_word(6'h21, 5'd5, 5'd6, 16'h7fff);
        mem[4] = r_word(6'h02, 5'd7, 5'd8, 5'd0, 11'h400);
        mem[5] = i_word(6'h3e, 5'd9, 5'd10, 16'h8000);
        mem[6] = r_word(6'h10, 5'd11, 5'd12, 5'd17, 11'h2aa);
        mem[7] = i_word(6'h22, 5'd13, 5'd14, 16'h0001);
    endtask

    task automatic wait_decode(output ifetch_pkg::decoded_t got);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!(dec_valid && dec_ready))
        begin
            cycles++;
            if (cycles > wait_limit)
            begin
                fail_run("timed out waiting for a decoded instruction");
            end
            @(posedge clk);
        end
        got = dec;
    endtask

    task automatic wait_refill();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!(ar_valid && ar_ready))
        begin
            cycles++;
            if (cycles > wait_limit)
            begin
                fail_run("timed out waiting for a refill read address handshake");
            end
            @(posedge clk);
        end
    endtask

    // walk the program from the reset pc and compare each decode
    task automatic run_program(input int count);
        logic [31:0]          pc;
        ifetch_pkg::decoded_t got;
        ifetch_pkg::decoded_t exp;
        pc = `IFETCH_RESET_PC;
        for (int n = 0; n < count; n++)
        begin
            exp = predict(pc);
            wait_decode(got);
            check_equal(got, exp, $sformatf("decode %0d at pc %h", n, pc));
            pc = next_pc(pc);
        end
    endtask

    task automatic straight_decode();
        load_straight();
        apply_reset();
        run_program(8);
    endtask

    task automatic jump_redirect();
        load_fill();
        mem[0] = r_word(6'h03, 5'd1, 5'd1, 5'd1, 11'h011);
        mem[1] = i_word(ifetch_pkg::opcode_jmp, 5'd0, 5'd0, 16'd5);
        mem[2] = r_word(6'h04, 5'd2, 5'd3, 5'd4, 11'h022);
        mem[3] = i_word(ifetch_pkg::opcode_jmp, 5'd0, 5'd0, 16'd16);
        mem[6] = i_word(6'h23, 5'd6, 5'd7, 16'hff00);
        mem[7] = i_word(ifetch_pkg::opcode_jmp, 5'd0, 5'd0, -16'sd5);
        apply_reset();
        run_program(8);
    endtask

    task automatic hit_reuse();
        load_fill();
        mem[0] = r_word(6'h05, 5'd1, 5'd2, 5'd3, 11'h100);
        mem[1] = i_word(6'h24, 5'd4, 5'd5, 16'h0040);
        mem[2] = r_word(6'h06, 5'd6, 5'd7, 5'd8, 11'h200);
        mem[3] = i_word(6'h25, 5'd9, 5'd10, 16'hc000);
        mem[4] = i_word(ifetch_pkg::opcode_jmp, 5'd0, 5'd0, -16'sd4);
        apply_reset();
        run_program(15);
        @(negedge clk);
        for (int k = 0; k < 5; k++)
        begin
            check_equal(ar_count[k], 1, $sformatf("AR count for loop word %0d", k));
        end
    endtask

    task automatic conflict_miss();
        // 0x00 and 0x40 share line 0
        load_fill();
        mem[0] = i_word(ifetch_pkg::opcode_jmp, 5'd0, 5'd0, 16'd16);
        mem[16] = i_word(ifetch_pkg::opcode_jmp, 5'd0, 5'd0, -16'sd16);
        apply_reset();
        run_program(6);
        @(negedge clk);
        check_equal(ar_count[0], 3, "AR count for address 0x00");
        check_equal(ar_count[16], 3, "AR count for address 0x40");
    endtask

    task automatic backpressure_replay();
        load_straight();
        mem[8] = i_word(ifetch_pkg::opcode_jmp, 5'd0, 5'd0, -16'sd8);
        apply_reset();
        bp_en = 1'b1;
        run_program(27);
        bp_en = 1'b0;
    endtask

    task automatic reset_mid_run();
        load_straight();
        apply_reset();
        run_program(3);
        wait_refill();
        apply_reset();
        run_program(1);
        @(negedge clk);
        check_equal(ar_count[0], 1, "AR count for the reset pc after reset");
    endtask

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r = '0;
        dec_ready = 1'b1;
        bp_en = 1'b0;
        stall_left = 0;
        rd_pending = 1'b0;
        rd_addr = '0;
        lfsr_state = 32'h5fba;
        straight_decode();
        jump_redirect();
        hit_reuse();
        conflict_miss();
        backpressure_replay();
        reset_mid_run();
        $display("Regression passed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
ifetch_pkg.sv
fetch_unit.sv
icache.sv
decode_stage.sv
ifetch_top.sv
ifetch_assert.sv
tb_ifetch.sv

/* Bender.yml */
package:
  name: ifetch

export_include_dirs:
  - .

sources:
  - files:
      - ifetch_pkg.sv
      - fetch_unit.sv
      - icache.sv
      - decode_stage.sv
      - ifetch_top.sv
  - target: test
    files:
      - ifetch_assert.sv
      - tb_ifetch.sv
